// File: project.f
+incdir+include
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/fetchStage.sv
hdl/pipeControl.sv
hdl/regFile.sv
hdl/executeStage.sv
hdl/memStage.sv
hdl/cpuTop.sv
tb/cpuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module cpuTb -o cpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0

// File: tb/cpuTb.sv
/* CPU testbench
   Random programs run on the DUT and on a sequential ISA model, retire streams compared */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpuTb;
    import isaPkg::*;
    import pipePkg::*;

    localparam int PROG_LEN    = 48;
    localparam int PRE_LEN     = 11;   // LBI r1..r7, then four stores
    localparam int RUN_TIMEOUT = 500;

    logic                               clk;
    logic                               arstN;
    logic                               run;
    logic                               loadEn;
    logic [$clog2(`CPU_IMEM_WORDS)-1:0] loadAddr;
    logic [`CPU_XLEN-1:0]               loadData;
    retireT                             retire;
    logic                               halted;
    logic                               err;

    logic [`CPU_XLEN-1:0] prog [PROG_LEN];
    retireT               expRec [PROG_LEN];   // Model retire stream
    retireT               nextExp;
    int                   expCount = 0;
    int                   expIdx;
    bit                   errExpected = 1'b0;
    logic [31:0]          rngState = 32'h3f7f;
    int                   retireErrs = 0;
    int                   stateErrs = 0;
    int                   endErrs = 0;

    cpuTop cpuTop_inst (
        .clk(clk), .arstN(arstN), .run(run),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .retire(retire), .halted(halted), .err(err)
    );

    always #10 clk = ~clk;

    always @(posedge clk or negedge arstN) begin
        if (!arstN)
            expIdx <= 0;
        else if (retire.valid)
            expIdx <= expIdx + 1;   // Step to the next model record
    end

    assign nextExp = (expIdx < expCount) ? expRec[expIdx] : '0;

    retireCheckA: assert property (@(posedge clk) disable iff (!arstN)
        retire.valid |-> nextExp.valid && retire.pc == nextExp.pc &&
            retire.regWrite == nextExp.regWrite && retire.halt == nextExp.halt &&
            (!nextExp.regWrite || (retire.rd == nextExp.rd && retire.value == nextExp.value)))
    else begin
        retireErrs++;
        $display("ERROR %0t: retire pc %h we %b rd %0d value %h halt %b", $time,
                 $sampled(retire.pc), $sampled(retire.regWrite), $sampled(retire.rd),
                 $sampled(retire.value), $sampled(retire.halt));
        $display("ERROR %0t: expected pc %h we %b rd %0d value %h halt %b (valid %b)",
                 $time, nextExp.pc, nextExp.regWrite, nextExp.rd, nextExp.value,
                 nextExp.halt, nextExp.valid);
    end

    idleQuietA: assert property (@(posedge clk) disable iff (!arstN)
        !run |-> !retire.valid && !halted && !err)
    else begin
        stateErrs++;
        $display("ERROR %0t: activity before run, retire %b halted %b err %b", $time,
                 $sampled(retire.valid), $sampled(halted), $sampled(err));
    end

    haltStickyA: assert property (@(posedge clk) disable iff (!arstN) halted |=> halted)
    else begin
        stateErrs++;
        $display("ERROR %0t: halted dropped before reset", $time);
    end

    haltRetireA: assert property (@(posedge clk) disable iff (!arstN)
        retire.valid && retire.halt |-> halted)
    else begin
        stateErrs++;
        $display("ERROR %0t: HALT retired without halted", $time);
    end

    afterHaltA: assert property (@(posedge clk) disable iff (!arstN)
        halted && !retire.halt |-> !retire.valid)
    else begin
        stateErrs++;
        $display("ERROR %0t: retire pc %h after halt", $time, $sampled(retire.pc));
    end

    errStickyA: assert property (@(posedge clk) disable iff (!arstN) err |=> err)
    else begin
        stateErrs++;
        $display("ERROR %0t: err dropped before reset", $time);
    end

    noErrA: assert property (@(posedge clk) disable iff (!arstN) !errExpected |-> !err)
    else begin
        stateErrs++;
        $display("ERROR %0t: err raised in a program without illegal opcodes", $time);
    end

    // Xorshift32
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic int randBelow(int n);
        return int'(nextRandom() % 32'(n));
    endfunction

    // r0 stays zero, so LD/ST at r0 + 0..3 only touch stored words
    task automatic buildProgram(input bit withIllegal);
        logic [2:0] lastRd;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] rt;
        int         maxOff;
        for (int i = 0; i < 7; i++)
            prog[i] = {OP_LBI, 3'(i + 1), 8'(randBelow(256))};
        for (int k = 0; k < 4; k++)
            prog[7 + k] = {OP_ST, 3'(k + 4), 3'd0, 5'(k)};
        lastRd = 3'd7;
        for (int i = PRE_LEN; i < PROG_LEN - 1; i++) begin
            rd     = 3'(1 + randBelow(7));
            rs     = (randBelow(2) == 0) ? lastRd : 3'(randBelow(8));   // Dependent half the time
            rt     = (randBelow(2) == 0) ? lastRd : 3'(randBelow(8));
            maxOff = PROG_LEN - 2 - i;   // Forward targets up to the HALT
            if (maxOff > 15)
                maxOff = 15;
            case (randBelow(12))
                0:       prog[i] = {OP_ADD, rd, rs, rt, 2'b00};
                1:       prog[i] = {OP_SUB, rd, rs, rt, 2'b00};
                2:       prog[i] = {OP_AND, rd, rs, rt, 2'b00};
                3:       prog[i] = {OP_XOR, rd, rs, rt, 2'b00};
                4:       prog[i] = {OP_ADDI, rd, rs, 5'(randBelow(32))};
                5:       prog[i] = {OP_LBI, rd, 8'(randBelow(256))};
                6, 7:    prog[i] = {OP_LD, rd, 3'd0, 5'(randBelow(4))};
                8: begin
                    prog[i] = {OP_ST, rt, 3'd0, 5'(randBelow(4))};
                    rd      = lastRd;
                end
                9: begin
                    rs      = (randBelow(3) == 0) ? 3'd0 : rs;   // r0 forces taken
                    prog[i] = {OP_BEQZ, 3'd0, rs, 5'(randBelow(maxOff + 1))};
                    rd      = lastRd;
                end
                10: begin
                    prog[i] = {OP_J, 11'(randBelow(maxOff + 1))};
                    rd      = lastRd;
                end
                default: begin
                    prog[i] = {OP_NOP, 11'(randBelow(2048))};
                    rd      = lastRd;
                end
            endcase
            lastRd = rd;
            if (withIllegal && (i == PRE_LEN || randBelow(10) == 0))
                prog[i] = {5'(12 + randBelow(20)), 11'(randBelow(2048))};
        end
        prog[PROG_LEN - 1] = {OP_HALT, 11'd0};
    endtask

    // Sequential ISA model
    task automatic modelProgram();
        logic [15:0] regs [8];
        logic [15:0] dmem [256];
        logic [15:0] w;
        logic [15:0] pc;
        logic [15:0] a;
        logic [15:0] imm5;
        logic [7:0]  addr;
        retireT      rec;
        bit          done;
        for (int i = 0; i < 8; i++)
            regs[i] = '0;
        pc          = '0;
        done        = 1'b0;
        expCount    = 0;
        errExpected = 1'b0;
        while (!done && int'(pc) < PROG_LEN) begin
            w        = prog[int'(pc)];
            a        = regs[w[7:5]];
            imm5     = {{11{w[4]}}, w[4:0]};
            addr     = 8'(a + imm5);
            rec      = '0;
            rec.valid = 1'b1;
            rec.pc   = pc;
            rec.rd   = w[10:8];
            pc       = pc + 16'd1;   // Targets are PC+1 plus offset
            case (w[15:11])
                OP_ADD:  rec.value = a + regs[w[4:2]];
                OP_SUB:  rec.value = a - regs[w[4:2]];
                OP_AND:  rec.value = a & regs[w[4:2]];
                OP_XOR:  rec.value = a ^ regs[w[4:2]];
                OP_ADDI: rec.value = a + imm5;
                OP_LBI:  rec.value = {{8{w[7]}}, w[7:0]};
                OP_LD:   rec.value = dmem[addr];
                OP_ST:   dmem[addr] = regs[w[10:8]];
                OP_BEQZ: if (a == 16'd0) pc = pc + imm5;
                OP_J:    pc = pc + {{5{w[10]}}, w[10:0]};
                OP_HALT: begin
                    rec.halt = 1'b1;
                    done     = 1'b1;
                end
                OP_NOP: ;
                default: begin
                    rec.valid   = 1'b0;   // Dropped, never retires
                    errExpected = 1'b1;
                end
            endcase
            rec.regWrite = rec.valid && w[15:11] inside {OP_ADD, OP_SUB, OP_AND, OP_XOR,
                                                         OP_ADDI, OP_LBI, OP_LD};
            if (rec.regWrite)
                regs[rec.rd] = rec.value;
            if (rec.valid) begin
                expRec[expCount] = rec;
                expCount++;
            end
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #2;
        arstN  = 1'b0;
        run    = 1'b0;
        loadEn = 1'b0;
        repeat (8) @(posedge clk);
        #2 arstN = 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            #2;
            loadEn   = 1'b1;
            loadAddr = 8'(i);
            loadData = prog[i];
        end
        @(posedge clk);
        #2 loadEn = 1'b0;
    endtask

    task automatic runProgram(input bit withIllegal, output bit timedOut);
        int n;
        buildProgram(withIllegal);
        modelProgram();
        applyReset();
        loadProgram();
        repeat (4) @(posedge clk);   // Idle with run low
        #2 run = 1'b1;
        n = 0;
        while (!halted && n < RUN_TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        timedOut = !halted;
        if (timedOut) begin
            $display("Timeout: halted did not rise within %0d cycles of run", RUN_TIMEOUT);
        end else begin
            repeat (6) @(posedge clk);   // Watch for stray retires
            #2;
            allRetiredA: assert (expIdx == expCount) else begin
                endErrs++;
                $display("ERROR %0t: %0d of %0d instructions retired", $time, expIdx, expCount);
            end
            errLevelA: assert (err == errExpected) else begin
                endErrs++;
                $display("ERROR %0t: err is %b, expected %b", $time, err, errExpected);
            end
        end
    endtask

    initial begin
        bit timedOut;
        clk      = 1'b0;
        arstN    = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        timedOut = 1'b0;
        runProgram(1'b0, timedOut);
        if (!timedOut)
            runProgram(1'b1, timedOut);   // Second program carries illegal words
        $display("Errors: %0d retire, %0d state, %0d end of run, %0d timeout",
                 retireErrs, stateErrs, endErrs, int'(timedOut));
        if (retireErrs == 0 && stateErrs == 0 && endErrs == 0 && !timedOut)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: hdl/cpuTop.sv
/* Pipelined 16-bit CPU
   Fetch, decode, execute, memory and writeback with forwarding and halt */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpuTop (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic                               run,
    input  logic                               loadEn,
    input  logic [$clog2(`CPU_IMEM_WORDS)-1:0] loadAddr,
    input  logic [`CPU_XLEN-1:0]               loadData,
    output pipePkg::retireT                    retire,
    output logic                               halted,
    output logic                               err
);
    import isaPkg::*;
    import pipePkg::*;

    ifIdT    ifId;
    ctrlT    idCtrl;
    wordT    idImm;
    logic    stall;
    logic    haltSeen;
    fwdSelE  fwdRs;
    fwdSelE  fwdRt;
    wordT    rsVal;
    wordT    rtVal;
    exMemT   exMem;
    ctrlT    exCtrl;
    regAddrT exRd;
    logic    redirect;
    wordT    redirectPc;
    memWbT   memWb;

    fetchStage #(.IMEM_WORDS(`CPU_IMEM_WORDS)) fetchStage_inst (
        .clk(clk), .arstN(arstN), .run(run),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .stall(stall), .haltSeen(haltSeen),
        .redirect(redirect), .redirectPc(redirectPc),
        .ifId(ifId)
    );

    pipeControl pipeControl_inst (
        .clk(clk), .arstN(arstN), .ifId(ifId),
        .exCtrl(exCtrl), .exRd(exRd),
        .exMemRead(exCtrl.memRead), .exRegWrite(exCtrl.regWrite),
        .memRd(exMem.ctrl.rd), .memRegWrite(exMem.ctrl.regWrite),
        .redirect(redirect),
        .idCtrl(idCtrl), .idImm(idImm), .stall(stall), .haltSeen(haltSeen),
        .fwdRs(fwdRs), .fwdRt(fwdRt), .err(err)
    );

    regFile regFile_inst (
        .clk(clk), .arstN(arstN),
        .rsAddr(ifId.instr.rs), .rtAddr(rtAddrOf(ifId.instr)),
        .wbEn(memWb.ctrl.regWrite), .wbAddr(memWb.ctrl.rd), .wbData(memWb.result),
        .rsVal(rsVal), .rtVal(rtVal)
    );

    executeStage executeStage_inst (
        .clk(clk), .arstN(arstN),
        .idCtrl(idCtrl), .idImm(idImm), .ifId(ifId),
        .rsVal(rsVal), .rtVal(rtVal), .fwdRs(fwdRs), .fwdRt(fwdRt),
        .stall(stall), .memWb(memWb),
        .exMem(exMem), .exCtrl(exCtrl), .exRd(exRd),
        .redirect(redirect), .redirectPc(redirectPc)
    );

    memStage #(.DMEM_WORDS(`CPU_DMEM_WORDS)) memStage_inst (
        .clk(clk), .arstN(arstN), .exMem(exMem),
        .memWb(memWb), .retire(retire), .halted(halted)
    );

endmodule

// File: hdl/memStage.sv
/* Memory stage
   Data memory, MEM/WB register, retire record and sticky halted */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module memStage #(
    parameter int DMEM_WORDS = `CPU_DMEM_WORDS
) (
    input  logic             clk,
    input  logic             arstN,
    input  pipePkg::exMemT   exMem,
    output pipePkg::memWbT   memWb,
    output pipePkg::retireT  retire,
    output logic             halted
);
    localparam int AW = $clog2(DMEM_WORDS);

    logic [`CPU_XLEN-1:0] dmem [DMEM_WORDS];
    logic [AW-1:0]        addr;

    assign addr = exMem.aluOut[AW-1:0];  // Upper address bits ignored

    always_ff @(posedge clk) begin
        if (exMem.ctrl.memWrite)
            dmem[addr] <= exMem.storeData;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memWb.ctrl      <= '0;
            retire.valid    <= 1'b0;
            retire.regWrite <= 1'b0;
            retire.halt     <= 1'b0;
            halted          <= 1'b0;
        end else begin
            memWb.ctrl      <= exMem.ctrl;
            memWb.pc        <= exMem.pc;
            memWb.result    <= exMem.ctrl.memRead ? dmem[addr] : exMem.aluOut;
            retire.valid    <= memWb.ctrl.valid;  // Same edge as the register write
            retire.pc       <= memWb.pc;
            retire.regWrite <= memWb.ctrl.regWrite;
            retire.rd       <= memWb.ctrl.rd;
            retire.value    <= memWb.result;
            retire.halt     <= memWb.ctrl.isHalt;
            if (memWb.ctrl.isHalt)
                halted <= 1'b1;
        end
    end

    addrKnownA: assert property (@(posedge clk) disable iff (!arstN)
        exMem.ctrl.memRead || exMem.ctrl.memWrite |-> !$isunknown(exMem.aluOut));

endmodule

// File: hdl/executeStage.sv
/* Execute stage
   ID/EX register, operand forwarding, ALU, branch resolution and EX/MEM */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module executeStage (
    input  logic                 clk,
    input  logic                 arstN,
    input  pipePkg::ctrlT        idCtrl,
    input  logic [`CPU_XLEN-1:0] idImm,
    input  pipePkg::ifIdT        ifId,
    input  logic [`CPU_XLEN-1:0] rsVal,
    input  logic [`CPU_XLEN-1:0] rtVal,
    input  pipePkg::fwdSelE      fwdRs,
    input  pipePkg::fwdSelE      fwdRt,
    input  logic                 stall,
    input  pipePkg::memWbT       memWb,
    output pipePkg::exMemT       exMem,
    output pipePkg::ctrlT        exCtrl,
    output isaPkg::regAddrT      exRd,
    output logic                 redirect,
    output logic [`CPU_XLEN-1:0] redirectPc
);
    import isaPkg::*;
    import pipePkg::*;

    idExT   idEx;
    fwdSelE fwdRsQ;
    fwdSelE fwdRtQ;
    wordT   opA;
    wordT   opT;
    wordT   opB;
    wordT   aluRes;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx.ctrl <= '0;
            fwdRsQ    <= FWD_REG;
            fwdRtQ    <= FWD_REG;
        end else begin
            if (stall || redirect)
                idEx.ctrl <= '0;  // Bubble
            else
                idEx.ctrl <= idCtrl;
            idEx.pc     <= ifId.pc;
            idEx.rsVal  <= rsVal;
            idEx.rtVal  <= rtVal;
            idEx.rsAddr <= ifId.instr.rs;
            idEx.rtAddr <= rtAddrOf(ifId.instr);
            idEx.imm    <= idImm;
            fwdRsQ      <= fwdRs;
            fwdRtQ      <= fwdRt;
        end
    end

    function automatic wordT fwdMux(fwdSelE sel, wordT regVal);
        case (sel)
            FWD_EXMEM: return exMem.aluOut;
            FWD_MEMWB: return memWb.result;
            default:   return regVal;
        endcase
    endfunction

    always_comb begin
        opA = fwdMux(fwdRsQ, idEx.rsVal);
        opT = fwdMux(fwdRtQ, idEx.rtVal);
        opB = idEx.ctrl.useImm ? idEx.imm : opT;
        case (idEx.ctrl.aluOp)
            ALU_SUB: aluRes = opA - opB;
            ALU_AND: aluRes = opA & opB;
            ALU_XOR: aluRes = opA ^ opB;
            default: aluRes = opA + opB;
        endcase
    end

    // Target is PC+1 plus offset for both BEQZ and J
    assign redirect   = idEx.ctrl.valid &&
                        (idEx.ctrl.isJump || (idEx.ctrl.isBranch && opA == '0));
    assign redirectPc = idEx.pc + 1'b1 + idEx.imm;
    assign exCtrl     = idEx.ctrl;
    assign exRd       = idEx.ctrl.rd;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem.ctrl <= '0;
        end else begin
            exMem.ctrl      <= idEx.ctrl;
            exMem.pc        <= idEx.pc;
            exMem.aluOut    <= idEx.ctrl.isLbi ? idEx.imm : aluRes;
            exMem.storeData <= opT;
        end
    end

    redirectSrcA: assert property (@(posedge clk) disable iff (!arstN)
        redirect |-> idEx.ctrl.valid && (idEx.ctrl.isBranch || idEx.ctrl.isJump));

endmodule

// File: hdl/regFile.sv
/* Register file
   Eight registers, two read ports and one write port with write-through */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module regFile (
    input  logic                 clk,
    input  logic                 arstN,
    input  isaPkg::regAddrT      rsAddr,
    input  isaPkg::regAddrT      rtAddr,
    input  logic                 wbEn,
    input  isaPkg::regAddrT      wbAddr,
    input  logic [`CPU_XLEN-1:0] wbData,
    output logic [`CPU_XLEN-1:0] rsVal,
    output logic [`CPU_XLEN-1:0] rtVal
);
    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `CPU_NREGS; i++)
                regs[i] <= '0;
        end else if (wbEn) begin
            regs[wbAddr] <= wbData;
        end
    end

    // Same-cycle write is visible to decode
    assign rsVal = (wbEn && wbAddr == rsAddr) ? wbData : regs[rsAddr];
    assign rtVal = (wbEn && wbAddr == rtAddr) ? wbData : regs[rtAddr];

endmodule

// File: hdl/pipeControl.sv
/* Pipeline control
   Decode into the control word, forwarding selects, load-use stall and sticky err */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module pipeControl (
    input  logic                 clk,
    input  logic                 arstN,
    input  pipePkg::ifIdT        ifId,
    input  pipePkg::ctrlT        exCtrl,
    input  isaPkg::regAddrT      exRd,
    input  logic                 exMemRead,
    input  logic                 exRegWrite,
    input  isaPkg::regAddrT      memRd,
    input  logic                 memRegWrite,
    input  logic                 redirect,
    output pipePkg::ctrlT        idCtrl,
    output logic [`CPU_XLEN-1:0] idImm,
    output logic                 stall,
    output logic                 haltSeen,
    output pipePkg::fwdSelE      fwdRs,
    output pipePkg::fwdSelE      fwdRt,
    output logic                 err
);
    import isaPkg::*;
    import pipePkg::*;

    localparam int XL = `CPU_XLEN;

    logic [XL-1:0] raw;
    regAddrT       rsA;
    regAddrT       rtA;
    logic          usesRs;
    logic          usesRt;
    logic          illegal;

    assign raw = ifId.instr;
    assign rsA = ifId.instr.rs;
    assign rtA = rtAddrOf(ifId.instr);

    always_comb begin
        idCtrl    = '0;
        idCtrl.rd = ifId.instr.rd;
        usesRs    = 1'b1;
        usesRt    = 1'b0;
        illegal   = 1'b0;
        case (ifId.instr.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                idCtrl.aluOp    = aluOpE'(ifId.instr.opcode[1:0]);
                idCtrl.regWrite = 1'b1;
                usesRt          = 1'b1;
            end
            OP_ADDI: begin
                idCtrl.useImm   = 1'b1;
                idCtrl.regWrite = 1'b1;
            end
            OP_LBI: begin
                idCtrl.isLbi    = 1'b1;
                idCtrl.regWrite = 1'b1;
                usesRs          = 1'b0;
            end
            OP_LD: begin
                idCtrl.useImm   = 1'b1;  // Address is rs + imm5
                idCtrl.memRead  = 1'b1;
                idCtrl.regWrite = 1'b1;
            end
            OP_ST: begin
                idCtrl.useImm   = 1'b1;
                idCtrl.memWrite = 1'b1;
                usesRt          = 1'b1;  // Data from the rd field
            end
            OP_BEQZ: idCtrl.isBranch = 1'b1;
            OP_J: begin
                idCtrl.isJump = 1'b1;
                usesRs        = 1'b0;
            end
            OP_HALT: begin
                idCtrl.isHalt = 1'b1;
                usesRs        = 1'b0;
            end
            OP_NOP: usesRs = 1'b0;
            default: begin
                illegal = 1'b1;
                usesRs  = 1'b0;
            end
        endcase
        if (ifId.valid && !illegal)
            idCtrl.valid = 1'b1;
        else
            idCtrl = '0;  // Bubble, illegal word dropped here
    end

    always_comb begin
        case (ifId.instr.opcode)
            OP_LBI:  idImm = {{(XL-8){raw[7]}}, raw[7:0]};
            OP_J:    idImm = {{(XL-11){raw[10]}}, raw[10:0]};
            default: idImm = {{(XL-5){raw[4]}}, raw[4:0]};
        endcase
    end

    // Youngest writer wins
    function automatic fwdSelE pickFwd(regAddrT a);
        if (exCtrl.valid && exRegWrite && exRd == a)
            return FWD_EXMEM;
        if (memRegWrite && memRd == a)
            return FWD_MEMWB;
        return FWD_REG;
    endfunction

    always_comb begin
        fwdRs = pickFwd(rsA);
        fwdRt = pickFwd(rtA);
    end

    // Load result is not ready until MEM/WB
    assign stall = ifId.valid && exCtrl.valid && exMemRead &&
                   ((usesRs && exRd == rsA) || (usesRt && exRd == rtA));

    assign haltSeen = idCtrl.isHalt && !redirect;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            err <= 1'b0;
        else if (ifId.valid && illegal && !redirect)
            err <= 1'b1;  // Sticky until reset
    end

    stallOnceA: assert property (@(posedge clk) disable iff (!arstN)
        stall |=> !stall);

endmodule

// File: hdl/fetchStage.sv
/* Fetch stage
   PC, instruction memory with program load port, run/halt state and IF/ID */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module fetchStage #(
    parameter int IMEM_WORDS = `CPU_IMEM_WORDS
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          run,
    input  logic                          loadEn,
    input  logic [$clog2(IMEM_WORDS)-1:0] loadAddr,
    input  logic [`CPU_XLEN-1:0]          loadData,
    input  logic                          stall,
    input  logic                          haltSeen,
    input  logic                          redirect,
    input  logic [`CPU_XLEN-1:0]          redirectPc,
    output pipePkg::ifIdT                 ifId
);
    import isaPkg::*;

    localparam int AW = $clog2(IMEM_WORDS);

    typedef enum logic [1:0] {FS_IDLE, FS_RUN, FS_HALT} fetchStateE;

    fetchStateE           state;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] imem [IMEM_WORDS];
    logic                 fetchOk;

    assign fetchOk = (state == FS_RUN) && !haltSeen;

    always_ff @(posedge clk) begin
        if (loadEn)
            imem[loadAddr] <= loadData;  // Only while run is low
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= FS_IDLE;
        end else begin
            case (state)
                FS_IDLE: if (run) state <= FS_RUN;
                FS_RUN:  if (haltSeen) state <= FS_HALT;
                default: state <= FS_HALT;  // Stays until reset
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc         <= '0;
            ifId.valid <= 1'b0;
        end else if (redirect) begin
            pc         <= redirectPc;  // Overrides a stall
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            ifId.valid <= fetchOk;     // Bubble once halted
            ifId.pc    <= pc;
            ifId.instr <= instrT'(imem[pc[AW-1:0]]);
            if (fetchOk)
                pc <= pc + 1'b1;
        end
    end

    pcHoldA: assert property (@(posedge clk) disable iff (!arstN)
        stall && !redirect |=> pc == $past(pc));

endmodule

// File: hdl/pipePkg.sv
/* Pipeline package
   Control word, forwarding selects, stage registers and the retire record */
`include "cpu_defs.svh"

package pipePkg;

    typedef logic [`CPU_XLEN-1:0] wordT;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR} aluOpE;
    typedef enum logic [1:0] {FWD_REG, FWD_EXMEM, FWD_MEMWB} fwdSelE;

    // All-zero word is a bubble
    typedef struct packed {
        logic            valid;
        aluOpE           aluOp;
        logic            useImm;     // Second operand from immediate
        logic            regWrite;
        logic            memRead;
        logic            memWrite;
        logic            isBranch;
        logic            isJump;
        logic            isHalt;
        logic            isLbi;
        isaPkg::regAddrT rd;
    } ctrlT;

    typedef struct packed {
        logic          valid;
        wordT          pc;
        isaPkg::instrT instr;
    } ifIdT;

    typedef struct packed {
        ctrlT            ctrl;
        wordT            pc;
        wordT            rsVal;
        wordT            rtVal;
        isaPkg::regAddrT rsAddr;
        isaPkg::regAddrT rtAddr;
        wordT            imm;        // Sign extended
    } idExT;

    typedef struct packed {
        ctrlT ctrl;
        wordT pc;
        wordT aluOut;                // Result or memory address
        wordT storeData;
    } exMemT;

    typedef struct packed {
        ctrlT ctrl;
        wordT pc;
        wordT result;
    } memWbT;

    typedef struct packed {
        logic            valid;
        wordT            pc;
        logic            regWrite;
        isaPkg::regAddrT rd;
        wordT            value;
        logic            halt;
    } retireT;

endpackage

// File: hdl/isaPkg.sv
/* Instruction set package
   Opcode encoding and the 16-bit instruction word layout */
`include "cpu_defs.svh"

package isaPkg;

    typedef logic [$clog2(`CPU_NREGS)-1:0] regAddrT;

    // Register ops come first so their low bits pick the ALU op
    typedef enum logic [4:0] {
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        OP_AND  = 5'd2,
        OP_XOR  = 5'd3,
        OP_ADDI = 5'd4,
        OP_LBI  = 5'd5,
        OP_LD   = 5'd6,
        OP_ST   = 5'd7,
        OP_BEQZ = 5'd8,
        OP_J    = 5'd9,
        OP_HALT = 5'd10,
        OP_NOP  = 5'd11
    } opcodeE;  // Other codes are illegal

    typedef struct packed {
        opcodeE     opcode;   // [15:11]
        regAddrT    rd;       // [10:8]
        regAddrT    rs;       // [7:5]
        logic [4:0] imm5;     // [4:0], rt lives in [4:2]
    } instrT;

    // Second read port address; ST reads its store data through rd
    function automatic regAddrT rtAddrOf(instrT i);
        if (i.opcode == OP_ST)
            return i.rd;
        return i.imm5[4:2];
    endfunction

endpackage

// File: include/cpu_defs.svh
/* CPU configuration
   Data width, register count and memory depths */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_XLEN        16    // Data and instruction width
`define CPU_NREGS       8
`define CPU_IMEM_WORDS  256   // Word addressed
`define CPU_DMEM_WORDS  256

`endif
